//--- files.f
mipsIsaPkg.sv
apbPkg.sv
RegisterFile.sv
Alu.sv
InstrDecoder.sv
ApbRegIf.sv
MipsExecUnit.sv
tb_MipsExecUnit_assertions.sv
tb_MipsExecUnit.sv

//--- Bender.yml
package:
  name: mips_exec_unit

sources:
  - mipsIsaPkg.sv
  - apbPkg.sv
  - RegisterFile.sv
  - Alu.sv
  - InstrDecoder.sv
  - ApbRegIf.sv
  - MipsExecUnit.sv
  - target: test
    files:
      - tb_MipsExecUnit_assertions.sv
      - tb_MipsExecUnit.sv

//--- tb_MipsExecUnit.sv
/* Self-checking testbench for MipsExecUnit built with REG_ADDR_BITS = 5.
   Every APB task starts and ends on a falling edge and takes 2 cycles */
`timescale 1ns/10ps

module tb_MipsExecUnit;
    import apbPkg::*;
    import mipsIsaPkg::*;

    localparam int TABLE_LEN      = 24;
    localparam int NUM_RANDOM     = 40;
    localparam int TIMEOUT_CYCLES = (TABLE_LEN + NUM_RANDOM + 8) * 6;

    logic     clock;
    logic     arstN;
    apbReq_t  apbIn;
    apbRsp_t  apbOut;

    // Stimulus table, one instruction per row
    string    tName  [TABLE_LEN];
    word_t    tInstr [TABLE_LEN];
    regAddr_t tDest  [TABLE_LEN];
    word_t    tExp   [TABLE_LEN];   // Dest contents after the instruction
    bit       tErr   [TABLE_LEN];   // PSLVERR expected
    int       tCount = 0;

    word_t    refRegs [32];         // Reference model of the register file
    int       seed = 32'h62ae_153d;
    int       cycles = 0;
    int       wordErrs = 0;
    int       flagErrs = 0;
    int       statusErrs = 0;
    int       retired = 0;          // Legal instructions issued
    int       illegals = 0;
    int       rnd;
    word_t    rdData;
    word_t    instr;
    word_t    nextVal;
    logic     err;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rdst;

    MipsExecUnit #(.REG_ADDR_BITS(5)) dut (
        .i_Clock (clock),
        .i_arstN (arstN),
        .i_Apb   (apbIn),
        .o_Apb   (apbOut)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // 4 ns period
    end

    // Watchdog, sized from the test length
    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout after %0d cycles, the test sequence did not complete", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Encoders and APB driver
    // ------------------------------------------------------------------------
    function automatic word_t encR(regAddr_t s, regAddr_t t, regAddr_t d,
                                   logic [4:0] sh, logic [5:0] fn);
        return {6'h00, s, t, d, sh, fn};
    endfunction

    function automatic word_t encI(logic [5:0] op, regAddr_t s, regAddr_t t,
                                   logic [15:0] imm);
        return {op, s, t, imm};
    endfunction

    function automatic apbAddr_t winAddr(regAddr_t r);
        return REG_BASE + {5'b0, r, 2'b00};  // Window slot of register r
    endfunction

    task automatic apbWrite(input apbAddr_t addr, input word_t data, output logic slvErr);
        apbIn = '{pSel: 1'b1, pEnable: 1'b0, pWrite: 1'b1, pAddr: addr, pWData: data};
        @(negedge clock);
        apbIn.pEnable = 1'b1;  // Access cycle
        #1 slvErr = apbOut.pSlvErr;
        @(negedge clock);
        apbIn.pSel    = 1'b0;
        apbIn.pEnable = 1'b0;
    endtask

    task automatic apbRead(input apbAddr_t addr, output word_t data, output logic slvErr);
        apbIn = '{pSel: 1'b1, pEnable: 1'b0, pWrite: 1'b0, pAddr: addr, pWData: '0};
        @(negedge clock);
        apbIn.pEnable = 1'b1;
        #1;                    // PRDATA settled, well before the rising edge
        data   = apbOut.pRData;
        slvErr = apbOut.pSlvErr;
        @(negedge clock);
        apbIn.pSel    = 1'b0;
        apbIn.pEnable = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic checkWord(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            wordErrs++;
            $display("mismatch %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic checkErr(input string name, input bit exp, input bit act);
        if (act !== exp) begin
            flagErrs++;
            $display("mismatch %s pslverr: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic checkStatus(input string name, input word_t exp, input word_t act);
        if (act[15:0] !== exp[15:0]) begin
            statusErrs++;
            $display("mismatch %s retired: expected %0d, actual %0d", name, exp[15:0], act[15:0]);
        end
        if (act[31:16] !== exp[31:16]) begin
            statusErrs++;
            $display("mismatch %s illegal: expected %0d, actual %0d", name, exp[31:16], act[31:16]);
        end
    endtask

    task automatic addEntry(input string name, input word_t ins, input regAddr_t dest,
                            input word_t exp, input bit expErr);
        tName[tCount]  = name;
        tInstr[tCount] = ins;
        tDest[tCount]  = dest;
        tExp[tCount]   = exp;
        tErr[tCount]   = expErr;
        tCount++;
    endtask

    // Expected values worked out by hand from the MIPS definitions
    task automatic loadTable();
        addEntry("addiu r1", encI(OPC_ADDIU, 0, 1, 16'h7FFF), 1, 32'h0000_7FFF, 0);
        addEntry("addiu r2", encI(OPC_ADDIU, 0, 2, 16'hFFFF), 2, 32'hFFFF_FFFF, 0);
        addEntry("lui r3", encI(OPC_LUI, 0, 3, 16'h8000), 3, 32'h8000_0000, 0);
        addEntry("ori r3", encI(OPC_ORI, 3, 3, 16'h0005), 3, 32'h8000_0005, 0);
        addEntry("addu wrap", encR(2, 1, 4, 0, FN_ADDU), 4, 32'h0000_7FFE, 0);
        addEntry("subu wrap", encR(1, 2, 5, 0, FN_SUBU), 5, 32'h0000_8000, 0);
        addEntry("and", encR(3, 2, 6, 0, FN_AND), 6, 32'h8000_0005, 0);
        addEntry("or", encR(1, 3, 7, 0, FN_OR), 7, 32'h8000_7FFF, 0);
        addEntry("xor", encR(3, 2, 8, 0, FN_XOR), 8, 32'h7FFF_FFFA, 0);
        addEntry("nor", encR(1, 3, 9, 0, FN_NOR), 9, 32'h7FFF_8000, 0);
        addEntry("slt signed", encR(3, 1, 10, 0, FN_SLT), 10, 32'h1, 0);
        addEntry("sltu unsigned", encR(3, 1, 11, 0, FN_SLTU), 11, 32'h0, 0);
        addEntry("sll 4", encR(0, 1, 12, 4, FN_SLL), 12, 32'h0007_FFF0, 0);
        addEntry("srl 4", encR(0, 3, 13, 4, FN_SRL), 13, 32'h0800_0000, 0);
        addEntry("sra 4", encR(0, 3, 14, 4, FN_SRA), 14, 32'hF800_0000, 0);
        addEntry("sra 31", encR(0, 3, 15, 31, FN_SRA), 15, 32'hFFFF_FFFF, 0);
        addEntry("srl 31", encR(0, 2, 16, 31, FN_SRL), 16, 32'h1, 0);
        addEntry("slti pos", encI(OPC_SLTI, 1, 17, 16'hFFFF), 17, 32'h0, 0);
        addEntry("slti neg", encI(OPC_SLTI, 3, 18, 16'hFFFF), 18, 32'h1, 0);
        addEntry("sltiu small", encI(OPC_SLTIU, 1, 19, 16'hFFFF), 19, 32'h1, 0);
        addEntry("sltiu big", encI(OPC_SLTIU, 2, 20, 16'h8000), 20, 32'h0, 0);
        addEntry("write r0", encI(OPC_ADDIU, 1, 0, 16'h0005), 0, 32'h0, 0);
        addEntry("bad opcode", encI(6'h3F, 0, 1, 16'h1234), 1, 32'h0000_7FFF, 1);
        addEntry("bad funct", encR(1, 1, 2, 0, 6'h3F), 2, 32'hFFFF_FFFF, 1);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        apbIn = '0;
        arstN = 1'b0;
        for (int r = 0; r < 32; r++) refRegs[r] = '0;
        loadTable();
        repeat (4) @(posedge clock);  // Reset held 4 cycles
        @(negedge clock);
        arstN = 1'b1;

        // Everything clear after reset
        for (int r = 0; r < 32; r++) begin
            apbRead(winAddr(r), rdData, err);
            checkWord($sformatf("reset r%0d", r), 32'h0, rdData);
            checkErr($sformatf("reset r%0d", r), 1'b0, err);
        end
        apbRead(STATUS_ADDR, rdData, err);
        checkStatus("reset status", 32'h0, rdData);
        checkErr("reset status", 1'b0, err);

        // Directed table, each instruction followed by a read of its dest
        for (int i = 0; i < TABLE_LEN; i++) begin
            apbWrite(INSTR_ADDR, tInstr[i], err);
            checkErr(tName[i], tErr[i], err);
            if (tErr[i]) begin
                illegals++;
            end else begin
                retired++;
                if (tDest[i] != 0) refRegs[tDest[i]] = tExp[i];
            end
            apbRead(winAddr(tDest[i]), rdData, err);
            checkWord(tName[i], tExp[i], rdData);
        end
        apbRead(STATUS_ADDR, rdData, err);
        checkStatus("table status", {illegals[15:0], retired[15:0]}, rdData);

        // Bad accesses answer with an error and leave the counters alone
        apbRead(12'h010, rdData, err);
        checkErr("unmapped read", 1'b1, err);
        apbWrite(12'h200, 32'hDEAD_BEEF, err);
        checkErr("unmapped write", 1'b1, err);
        apbWrite(STATUS_ADDR, 32'h0, err);
        checkErr("status write", 1'b1, err);
        apbWrite(winAddr(1), 32'h0000_1234, err);
        checkErr("window write", 1'b1, err);
        apbRead(STATUS_ADDR, rdData, err);
        checkStatus("status after bad access", {illegals[15:0], retired[15:0]}, rdData);

        // Random ADDIU / XOR chain against the reference array
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd  = $random(seed);
            rs   = rnd[4:0];
            rt   = rnd[9:5];
            rdst = regAddr_t'(1 + (rnd[14:10] % 31));  // Never r0
            if (rnd[15]) begin
                instr   = encR(rs, rt, rdst, 5'd0, FN_XOR);
                nextVal = refRegs[rs] ^ refRegs[rt];
            end else begin
                instr   = encI(OPC_ADDIU, rs, rdst, rnd[31:16]);
                nextVal = refRegs[rs] + {{16{rnd[31]}}, rnd[31:16]};
            end
            apbWrite(INSTR_ADDR, instr, err);
            checkErr($sformatf("random %0d", n), 1'b0, err);
            refRegs[rdst] = nextVal;
            retired++;
        end

        // Full read-back
        for (int r = 0; r < 32; r++) begin
            apbRead(winAddr(r), rdData, err);
            checkWord($sformatf("final r%0d", r), refRegs[r], rdData);
        end
        apbRead(STATUS_ADDR, rdData, err);
        checkStatus("final status", {illegals[15:0], retired[15:0]}, rdData);

        $display("errors: word %0d, pslverr %0d, status %0d, assertion %0d",
                 wordErrs, flagErrs, statusErrs, dut.u_assertions.assertErrs);
        if ((wordErrs + flagErrs + statusErrs + dut.u_assertions.assertErrs) == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tb_MipsExecUnit_assertions.sv
/* Bound into every MipsExecUnit instance. Checks hold only outside reset */
`timescale 1ns/10ps

module tb_MipsExecUnit_assertions (
    input logic            i_Clock,
    input logic            i_arstN,
    input apbPkg::apbReq_t i_Req,
    input apbPkg::apbRsp_t i_Rsp
);
    import apbPkg::*;

    logic access;          // Second cycle of a transfer
    int   assertErrs = 0;  // Failures so far

    assign access = i_Req.pSel & i_Req.pEnable;

    // No wait states in this design
    assert property (@(posedge i_Clock) disable iff (!i_arstN) i_Rsp.pReady)
        else begin
            $error("PREADY dropped low");
            assertErrs++;
        end

    // Error response only in an access cycle
    assert property (@(posedge i_Clock) disable iff (!i_arstN) i_Rsp.pSlvErr |-> access)
        else begin
            $error("PSLVERR high outside an access cycle");
            assertErrs++;
        end

    // Window slot 0 is register 0
    assert property (@(posedge i_Clock) disable iff (!i_arstN)
        (access && !i_Req.pWrite && i_Req.pAddr == REG_BASE) |-> (i_Rsp.pRData == '0))
        else begin
            $error("window read of register 0 returned nonzero data");
            assertErrs++;
        end

endmodule

bind MipsExecUnit tb_MipsExecUnit_assertions u_assertions (
    .i_Clock (i_Clock),
    .i_arstN (i_arstN),
    .i_Req   (i_Apb),
    .i_Rsp   (o_Apb)
);

//--- MipsExecUnit.sv
/* One instruction per APB write to INSTR, retired at the end of its access
   cycle. REG_ADDR_BITS from 3 to 5 sets the implemented register count */
`timescale 1ns/10ps

module MipsExecUnit #(
    parameter int REG_ADDR_BITS = 5  // Register index bits actually built
) (
    input  logic            i_Clock,
    input  logic            i_arstN,
    input  apbPkg::apbReq_t i_Apb,
    output apbPkg::apbRsp_t o_Apb
);
    import mipsIsaPkg::*;

    word_t    instr;      // Word under decode
    logic     issue;      // Legal INSTR write strobe
    decCtrl_t ctrl;
    regAddr_t rdAddrA;    // Window index or rs
    word_t    rdDataA;
    word_t    rdDataB;
    word_t    aluResult;

    // ------------------------------------------------------------------------
    // Bus side
    // ------------------------------------------------------------------------
    ApbRegIf #(.REG_ADDR_BITS(REG_ADDR_BITS)) u_ApbRegIf (
        .i_Clock   (i_Clock),
        .i_arstN   (i_arstN),
        .i_Req     (i_Apb),
        .i_Illegal (ctrl.illegal),
        .i_DecRs   (ctrl.rs),
        .i_RdDataA (rdDataA),
        .o_Rsp     (o_Apb),
        .o_Instr   (instr),
        .o_Issue   (issue),
        .o_RdAddrA (rdAddrA)
    );

    InstrDecoder #(.REG_ADDR_BITS(REG_ADDR_BITS)) u_InstrDecoder (
        .i_Instr (instr),
        .o_Ctrl  (ctrl)
    );

    // ------------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------------
    RegisterFile #(.REG_ADDR_BITS(REG_ADDR_BITS)) u_RegisterFile (
        .i_Clock    (i_Clock),
        .i_arstN    (i_arstN),
        .i_WrAddr   (ctrl.dest),
        .i_WrData   (aluResult),
        .i_WrEnable (ctrl.wrEn & issue),  // Write only on the issuing edge
        .i_RdAddrA  (rdAddrA),
        .i_RdAddrB  (ctrl.rt),
        .o_RdDataA  (rdDataA),
        .o_RdDataB  (rdDataB)
    );

    Alu u_Alu (
        .i_Op     (ctrl.aluOp),
        .i_A      (rdDataA),
        .i_B      (ctrl.useImm ? ctrl.imm : rdDataB),  // I-type takes the immediate
        .i_Shamt  (ctrl.shamt),
        .o_Result (aluResult)
    );

endmodule

//--- ApbRegIf.sv
/* Zero wait states, PREADY tied high. Counters are 16 bits each and wrap,
   STATUS reads {illegal, retired}. Reads of INSTR return zero */
`timescale 1ns/10ps

module ApbRegIf #(
    parameter int REG_ADDR_BITS = 5  // Window slots beyond 2**bits answer with error
) (
    input  logic                 i_Clock,
    input  logic                 i_arstN,
    input  apbPkg::apbReq_t      i_Req,
    input  logic                 i_Illegal,   // From decoder
    input  mipsIsaPkg::regAddr_t i_DecRs,
    input  mipsIsaPkg::word_t    i_RdDataA,
    output apbPkg::apbRsp_t      o_Rsp,
    output mipsIsaPkg::word_t    o_Instr,
    output logic                 o_Issue,     // Legal INSTR write, access cycle only
    output mipsIsaPkg::regAddr_t o_RdAddrA
);
    import apbPkg::*;
    import mipsIsaPkg::*;

    localparam int       NUM_REGS     = 2 ** REG_ADDR_BITS;
    localparam apbAddr_t WIN_IDX_MASK = 12'h07C;  // Bits 6:2 select the window slot

    logic        access;      // Second cycle of a transfer
    logic        hitInstr;
    logic        hitStatus;
    logic        hitWindow;
    logic        winInRange;
    logic        instrWr;     // Any INSTR write in access phase
    logic        addrErr;
    regAddr_t    winIdx;
    logic [15:0] retiredCnt;
    logic [15:0] illegalCnt;
    word_t       status;

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------
    assign access     = i_Req.pSel & i_Req.pEnable;
    assign hitInstr   = (i_Req.pAddr == INSTR_ADDR);
    assign hitStatus  = (i_Req.pAddr == STATUS_ADDR);
    assign hitWindow  = ((i_Req.pAddr & ~WIN_IDX_MASK) == REG_BASE);  // Word aligned only
    assign winIdx     = i_Req.pAddr[6:2];
    assign winInRange = (winIdx < NUM_REGS);
    assign instrWr    = access & i_Req.pWrite & hitInstr;

    // Unmapped, write to a read-only slot, or window past the register count
    assign addrErr = !(hitInstr | hitStatus | hitWindow) |
                     (i_Req.pWrite & !hitInstr) |
                     (hitWindow & !winInRange);

    // Instruction path
    assign o_Instr   = i_Req.pWData;
    assign o_Issue   = instrWr & !i_Illegal;
    assign o_RdAddrA = hitWindow ? winIdx : i_DecRs;  // Window borrows port A

    assign status = {illegalCnt, retiredCnt};

    // Response, combinational in the access cycle
    always_comb begin
        o_Rsp.pReady  = 1'b1;
        o_Rsp.pSlvErr = access & (addrErr | (instrWr & i_Illegal));
        if (hitStatus) begin
            o_Rsp.pRData = status;
        end else if (hitWindow & winInRange) begin
            o_Rsp.pRData = i_RdDataA;
        end else begin
            o_Rsp.pRData = '0;
        end
    end

    // Retire and illegal counters, same edge as the register write
    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            retiredCnt <= '0;
            illegalCnt <= '0;
        end else if (instrWr) begin
            if (i_Illegal) begin
                illegalCnt <= illegalCnt + 16'd1;
            end else begin
                retiredCnt <= retiredCnt + 16'd1;
            end
        end
    end

endmodule

//--- InstrDecoder.sv
/* Combinational. wrEn only marks an instruction as writing a register,
   the actual write still needs the issue strobe from the bus side */
`timescale 1ns/10ps

module InstrDecoder #(
    parameter int REG_ADDR_BITS = 5  // Fields at or above 2**bits are illegal
) (
    input  mipsIsaPkg::word_t    i_Instr,
    output mipsIsaPkg::decCtrl_t o_Ctrl
);
    import mipsIsaPkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_BITS;

    opcode_e  opcode;
    funct_e   funct;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;
    logic     rType;       // SPECIAL opcode
    logic     knownOp;     // Encoding is supported
    logic     immSigned;   // Sign- vs zero-extend imm
    logic     regRangeErr; // Field beyond implemented registers

    // Instruction fields
    assign opcode = opcode_e'(i_Instr[31:26]);
    assign funct  = funct_e'(i_Instr[5:0]);
    assign rs     = i_Instr[25:21];
    assign rt     = i_Instr[20:16];
    assign rd     = i_Instr[15:11];
    assign rType  = (opcode == OPC_SPECIAL);

    // rd only matters for R-type, I-type reuses those bits as immediate
    assign regRangeErr = (rs >= NUM_REGS) || (rt >= NUM_REGS) ||
                         (rType && (rd >= NUM_REGS));

    always_comb begin
        knownOp   = 1'b1;
        immSigned = 1'b0;
        o_Ctrl    = '0;
        case (opcode)
            OPC_SPECIAL: begin
                case (funct)
                    FN_SLL:  o_Ctrl.aluOp = ALU_SLL;
                    FN_SRL:  o_Ctrl.aluOp = ALU_SRL;
                    FN_SRA:  o_Ctrl.aluOp = ALU_SRA;
                    FN_ADDU: o_Ctrl.aluOp = ALU_ADD;
                    FN_SUBU: o_Ctrl.aluOp = ALU_SUB;
                    FN_AND:  o_Ctrl.aluOp = ALU_AND;
                    FN_OR:   o_Ctrl.aluOp = ALU_OR;
                    FN_XOR:  o_Ctrl.aluOp = ALU_XOR;
                    FN_NOR:  o_Ctrl.aluOp = ALU_NOR;
                    FN_SLT:  o_Ctrl.aluOp = ALU_SLT;
                    FN_SLTU: o_Ctrl.aluOp = ALU_SLTU;
                    default: knownOp = 1'b0;
                endcase
            end
            OPC_ADDIU: begin
                o_Ctrl.aluOp = ALU_ADD;
                immSigned    = 1'b1;
            end
            OPC_SLTI: begin
                o_Ctrl.aluOp = ALU_SLT;
                immSigned    = 1'b1;
            end
            OPC_SLTIU: begin
                o_Ctrl.aluOp = ALU_SLTU;
                immSigned    = 1'b1;  // Extended signed, compared unsigned
            end
            OPC_ANDI: o_Ctrl.aluOp = ALU_AND;
            OPC_ORI:  o_Ctrl.aluOp = ALU_OR;
            OPC_XORI: o_Ctrl.aluOp = ALU_XOR;
            OPC_LUI:  o_Ctrl.aluOp = ALU_LUI;
            default:  knownOp = 1'b0;
        endcase

        // Common fields
        o_Ctrl.rs      = rs;
        o_Ctrl.rt      = rt;
        o_Ctrl.dest    = rType ? rd : rt;
        o_Ctrl.useImm  = !rType;
        o_Ctrl.imm     = immSigned ? {{16{i_Instr[15]}}, i_Instr[15:0]}
                                   : {16'h0000, i_Instr[15:0]};
        o_Ctrl.shamt   = i_Instr[10:6];
        o_Ctrl.illegal = !knownOp || regRangeErr;
        o_Ctrl.wrEn    = !o_Ctrl.illegal;
    end

endmodule

//--- Alu.sv
/* Purely combinational. Shifts take rt on i_B and the instruction shamt,
   LUI expects the zero-extended immediate on i_B */
`timescale 1ns/10ps

module Alu (
    input  mipsIsaPkg::aluOp_e i_Op,
    input  mipsIsaPkg::word_t  i_A,      // rs
    input  mipsIsaPkg::word_t  i_B,      // rt or immediate
    input  logic [4:0]         i_Shamt,  // From decCtrl_t.shamt
    output mipsIsaPkg::word_t  o_Result
);
    import mipsIsaPkg::*;

    logic ltSigned;    // A < B, two's complement
    logic ltUnsigned;  // A < B, magnitude

    assign ltSigned   = $signed(i_A) < $signed(i_B);
    assign ltUnsigned = i_A < i_B;

    always_comb begin
        case (i_Op)
            // Arithmetic wraps, no overflow trap
            ALU_ADD:  o_Result = i_A + i_B;
            ALU_SUB:  o_Result = i_A - i_B;

            // Bitwise logic
            ALU_AND:  o_Result = i_A & i_B;
            ALU_OR:   o_Result = i_A | i_B;
            ALU_XOR:  o_Result = i_A ^ i_B;
            ALU_NOR:  o_Result = ~(i_A | i_B);

            // Set-less-than, result is 0 or 1
            ALU_SLT:  o_Result = {31'b0, ltSigned};
            ALU_SLTU: o_Result = {31'b0, ltUnsigned};

            // Shifts of rt by shamt
            ALU_SLL:  o_Result = i_B << i_Shamt;
            ALU_SRL:  o_Result = i_B >> i_Shamt;
            ALU_SRA:  o_Result = word_t'($signed(i_B) >>> i_Shamt);  // Sign fill

            ALU_LUI:  o_Result = {i_B[15:0], 16'h0000};  // Immediate to upper half
            default:  o_Result = '0;
        endcase
    end

endmodule

//--- RegisterFile.sv
/* Register 0 has no storage and reads zero. Only the low REG_ADDR_BITS
   of each index are decoded, so range checks belong to the callers */
`timescale 1ns/10ps

module RegisterFile #(
    parameter int REG_ADDR_BITS = 5  // Implemented index bits, 3 to 5
) (
    input  logic                 i_Clock,
    input  logic                 i_arstN,
    // Write port
    input  mipsIsaPkg::regAddr_t i_WrAddr,
    input  mipsIsaPkg::word_t    i_WrData,
    input  logic                 i_WrEnable,
    // Read ports
    input  mipsIsaPkg::regAddr_t i_RdAddrA,
    input  mipsIsaPkg::regAddr_t i_RdAddrB,
    output mipsIsaPkg::word_t    o_RdDataA,
    output mipsIsaPkg::word_t    o_RdDataB
);
    import mipsIsaPkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_BITS;

    word_t                    regs [1:NUM_REGS-1];  // Registers 1..N-1
    logic [REG_ADDR_BITS-1:0] wrIdx;
    logic [REG_ADDR_BITS-1:0] rdIdxA;
    logic [REG_ADDR_BITS-1:0] rdIdxB;

    // Implemented index bits
    assign wrIdx  = i_WrAddr[REG_ADDR_BITS-1:0];
    assign rdIdxA = i_RdAddrA[REG_ADDR_BITS-1:0];
    assign rdIdxB = i_RdAddrB[REG_ADDR_BITS-1:0];

    // Write at the clock edge, register 0 silently dropped
    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_WrEnable && (wrIdx != '0)) begin
            regs[wrIdx] <= i_WrData;
        end
    end

    // Combinational reads
    assign o_RdDataA = (rdIdxA == '0) ? '0 : regs[rdIdxA];
    assign o_RdDataB = (rdIdxB == '0) ? '0 : regs[rdIdxB];

endmodule

//--- apbPkg.sv
/* APB3 without wait states, 12-bit byte address space.
   Register window holds 32 word slots starting at REG_BASE */
package apbPkg;

    typedef logic [11:0] apbAddr_t;  // Byte address
    typedef logic [31:0] apbData_t;  // Bus data word

    // Requester to completer
    typedef struct packed {
        logic     pSel;
        logic     pEnable;
        logic     pWrite;
        apbAddr_t pAddr;
        apbData_t pWData;
    } apbReq_t;

    // Completer to requester
    typedef struct packed {
        apbData_t pRData;
        logic     pReady;
        logic     pSlvErr;
    } apbRsp_t;

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------
    localparam apbAddr_t INSTR_ADDR  = 12'h000;  // Write issues one instruction
    localparam apbAddr_t STATUS_ADDR = 12'h004;  // {illegal, retired} counts
    localparam apbAddr_t REG_BASE    = 12'h080;  // Register n at REG_BASE + 4n

endpackage

//--- mipsIsaPkg.sv
/* MIPS32 integer subset only, with no memory, branch or HI/LO encodings.
   Opcode and funct enums carry the architectural field values */
package mipsIsaPkg;

    typedef logic [31:0] word_t;     // Data word and instruction word
    typedef logic [4:0]  regAddr_t;  // Register index as encoded in rs/rt/rd

    // Major opcode, instruction bits 31:26
    typedef enum logic [5:0] {
        OPC_SPECIAL = 6'h00,  // R-type, operation in funct
        OPC_ADDIU   = 6'h09,
        OPC_SLTI    = 6'h0A,
        OPC_SLTIU   = 6'h0B,
        OPC_ANDI    = 6'h0C,
        OPC_ORI     = 6'h0D,
        OPC_XORI    = 6'h0E,
        OPC_LUI     = 6'h0F
    } opcode_e;

    // SPECIAL funct, instruction bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } aluOp_e;

    // Decoded control for one instruction
    typedef struct packed {
        regAddr_t   rs;       // Source A
        regAddr_t   rt;       // Source B, shift source
        regAddr_t   dest;     // rd for R-type, rt for I-type
        aluOp_e     aluOp;
        logic       useImm;   // Operand B from imm, not rt
        word_t      imm;      // Already extended
        logic [4:0] shamt;
        logic       wrEn;     // Instruction writes a register
        logic       illegal;
    } decCtrl_t;

endpackage
